// File: files.f
hw/soc_pkg.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/axi_uart.sv
hw/axi_clint.sv
hw/soc_top.sv
bench/tb_soc_asserts.sv
bench/tb_soc.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f --top-module tb_soc -o tb_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_soc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: bench/tb_soc.sv
`timescale 1ns/1ps

module tb_soc
    import soc_pkg::*;
();

    logic        clk, rst;
    axi_ar_t     ifu_ar, lsu_ar;
    axi_aw_t     lsu_aw;
    axi_w_t      lsu_w;
    axi_r_t      ifu_r, lsu_r;
    axi_b_t      lsu_b;
    logic        ifu_arready, ifu_rready, lsu_arready, lsu_awready, lsu_wready;
    logic        lsu_rready, lsu_bready;
    logic [7:0]  tx_byte;
    logic        tx_strobe;

    logic [31:0] image [int];       // sram words by index.
    logic [7:0]  uart_ref;
    logic [31:0] snap_ref;          // expected clint high word.
    logic [63:0] cyc;               // follows mtime.
    int          tx_count;
    logic [7:0]  tx_seen;
    string       chk_name [$];
    logic [63:0] chk_got [$];
    logic [63:0] chk_exp [$];

    soc_top i_dut (.*);

    bind axi_xbar tb_soc_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst)
            cyc <= 64'd0;
        else
            cyc <= cyc + 64'd1;
    end

    always @(negedge clk) begin
        if (tx_strobe) begin
            tx_count++;
            tx_seen = tx_byte;
        end
    end

    always @(negedge clk) begin
        while (chk_name.size() > 0)
            check(chk_name.pop_front(), chk_got.pop_front(), chk_exp.pop_front());
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic void queue_check(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
    endfunction

    task automatic next_cycle(inout int waited, input string what);
        @(negedge clk);
        waited++;
        if (waited > 100) begin
            $display("timed out at %0d ns waiting for %s", $time, what);
            $display("STATUS: FAIL");
            $fatal(1, "handshake timeout");
        end
    endtask

    // expected {resp, data} of a read, at is the cycle of the ar transfer.
    function automatic logic [33:0] ref_read(input logic [31:0] addr, input logic [63:0] at);
        if (addr >= sram_base && addr < sram_base + 32'h0001_0000)
            return {resp_okay, image[int'(addr[15:2])]};
        if (addr == uart_addr)
            return {resp_okay, 24'h0, uart_ref};
        if (addr == clint_lo_addr)
            return {resp_okay, at[31:0]};
        if (addr == clint_hi_addr)
            return {resp_okay, snap_ref};
        return {resp_decerr, 32'h0};
    endfunction

    function automatic logic [1:0] ref_write(input logic [31:0] addr, input logic [31:0] data,
                                             input logic [3:0] strb);
        int          idx;
        logic [31:0] word;
        idx = int'(addr[15:2]);
        if (addr >= sram_base && addr < sram_base + 32'h0001_0000) begin
            word = image.exists(idx) ? image[idx] : 32'hx;
            for (int i = 0; i < 4; i++) begin
                if (strb[i])
                    word[8*i +: 8] = data[8*i +: 8];
            end
            image[idx] = word;
            return resp_okay;
        end
        if (addr == uart_addr) begin
            if (strb[0])
                uart_ref = data[7:0];
            return resp_okay;
        end
        return resp_decerr;         // clint writes land here too.
    endfunction

    task automatic do_read(input bit from_ifu, input logic [31:0] addr, input int stall,
                           output logic [31:0] data);
        int          waited;
        logic [63:0] at;
        logic [33:0] exp;
        axi_r_t      r;
        @(posedge clk);
        #1;
        if (from_ifu)
            ifu_ar = '{addr: addr, valid: 1'b1};
        else
            lsu_ar = '{addr: addr, valid: 1'b1};
        waited = 0;
        do
            next_cycle(waited, "arready");
        while (!(from_ifu ? ifu_arready : lsu_arready));
        at = cyc;
        @(posedge clk);
        #1;
        if (from_ifu)
            ifu_ar.valid = 1'b0;
        else
            lsu_ar.valid = 1'b0;
        repeat (stall) begin        // back-pressure on r.
            @(posedge clk);
            #1;
        end
        if (from_ifu)
            ifu_rready = 1'b1;
        else
            lsu_rready = 1'b1;
        waited = 0;
        do
            next_cycle(waited, "rvalid");
        while (!(from_ifu ? ifu_r.valid : lsu_r.valid));
        r = from_ifu ? ifu_r : lsu_r;
        @(posedge clk);
        #1;
        if (from_ifu)
            ifu_rready = 1'b0;
        else
            lsu_rready = 1'b0;
        exp  = ref_read(addr, at);
        data = r.data;
        queue_check(from_ifu ? "ifu_r.data" : "lsu_r.data", 64'(r.data), 64'(exp[31:0]));
        queue_check(from_ifu ? "ifu_r.resp" : "lsu_r.resp", 64'(r.resp), 64'(exp[33:32]));
        if (addr == clint_lo_addr)
            snap_ref = at[63:32];
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int         waited;
        int         stall;
        logic [1:0] resp;
        stall = $urandom_range(2, 0);
        @(posedge clk);
        #1;
        lsu_aw = '{addr: addr, valid: 1'b1};
        lsu_w  = '{data: data, strb: strb, valid: 1'b1};
        waited = 0;
        do
            next_cycle(waited, "awready and wready");
        while (!(lsu_awready && lsu_wready));
        @(posedge clk);
        #1;
        lsu_aw.valid = 1'b0;
        lsu_w.valid  = 1'b0;
        repeat (stall) begin        // back-pressure on b.
            @(posedge clk);
            #1;
        end
        lsu_bready = 1'b1;
        waited = 0;
        do
            next_cycle(waited, "bvalid");
        while (!lsu_b.valid);
        resp = lsu_b.resp;
        @(posedge clk);
        #1;
        lsu_bready = 1'b0;
        queue_check("lsu_b.resp", 64'(resp), 64'(ref_write(addr, data, strb)));
    endtask

    initial begin
        logic [31:0] addrs [8];
        logic [31:0] d, e;
        logic [63:0] t1, t2;
        int          tx_before;
        void'($urandom(32'hd9205c17));
        rst        = 1'b1;
        ifu_ar     = '0;
        lsu_ar     = '0;
        lsu_aw     = '0;
        lsu_w      = '0;
        ifu_rready = 1'b0;
        lsu_rready = 1'b0;
        lsu_bready = 1'b0;
        uart_ref   = 8'h0;
        snap_ref   = 32'h0;
        tx_count   = 0;
        tx_seen    = 8'h0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // sram image, full word first then a random byte merge.
        foreach (addrs[i]) begin
            addrs[i] = sram_base | {16'h0, 14'($urandom), 2'b00};
            do_write(addrs[i], $urandom, 4'hf);
            do_write(addrs[i], $urandom, 4'($urandom));
        end
        foreach (addrs[i]) begin
            do_read(1'b0, addrs[i], 0, d);
            do_read(1'b1, addrs[i], 0, d);
        end

        tx_before = tx_count;
        e = $urandom;
        do_write(uart_addr, e, 4'hf);
        do_read(1'b0, uart_addr, 1, d);
        queue_check("tx_strobe pulses", 64'(tx_count - tx_before), 64'd1);
        queue_check("tx_byte", 64'(tx_seen), 64'(e[7:0]));

        do_read(1'b0, clint_lo_addr, 0, d);
        do_read(1'b0, clint_hi_addr, 0, e);
        t1 = {e, d};
        repeat ($urandom_range(20, 5)) @(posedge clk);
        do_read(1'b0, clint_lo_addr, 0, d);
        do_read(1'b0, clint_hi_addr, 2, e);
        t2 = {e, d};
        queue_check("mtime rises", 64'(t2 > t1), 64'd1);

        // unmapped targets, then the sram image must be intact.
        do_read(1'b0, 32'h4000_0000, 2, d);
        do_read(1'b0, sram_base + 32'h0001_0000, 0, d);
        do_write(32'h4000_0000, $urandom, 4'hf);
        do_write(clint_lo_addr, $urandom, 4'hf);
        do_write({16'h8001, addrs[0][15:0]}, $urandom, 4'hf);   // just past the window.
        foreach (addrs[i])
            do_read(1'b0, addrs[i], 0, d);

        for (int n = 0; n < 6; n++) begin
            fork
                do_read(1'b1, addrs[n], $urandom_range(4, 0), d);
                do_read(1'b0, addrs[7 - n], $urandom_range(4, 0), e);
            join
        end

        repeat (3) @(posedge clk);
        if (chk_name.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("results were left uncompared at the end of the run");
            $display("STATUS: FAIL");
            $fatal(1, "uncompared results");
        end
    end

endmodule

// File: bench/tb_soc_asserts.sv
`timescale 1ns/1ps

module tb_soc_asserts
    import soc_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [1:0] state,            // grant fsm, 1 is ifu and 2 is lsu.
    input axi_ar_t    ifu_ar, lsu_ar, sram_ar,
    input logic       sram_arready,
    input axi_aw_t    lsu_aw,
    input axi_w_t     lsu_w,
    input axi_r_t     ifu_r, lsu_r,
    input axi_b_t     lsu_b,
    input logic       ifu_arready, ifu_rready, lsu_arready, lsu_awready, lsu_wready,
    input logic       lsu_rready, lsu_bready
);

    // requests hold until accepted.
    a_ifu_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_ar.valid && !ifu_arready |=> ifu_ar.valid && $stable(ifu_ar.addr))
        else $error("ifu ar dropped or changed before arready");
    a_lsu_ar_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_ar.valid && !lsu_arready |=> lsu_ar.valid && $stable(lsu_ar.addr))
        else $error("lsu ar dropped or changed before arready");
    a_lsu_aw_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_aw.valid && !lsu_awready |=> lsu_aw.valid && $stable(lsu_aw.addr))
        else $error("lsu aw dropped or changed before awready");
    a_lsu_w_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_w.valid && !lsu_wready |=> lsu_w.valid && $stable(lsu_w.data)
        && $stable(lsu_w.strb))
        else $error("lsu w dropped or changed before wready");

    // responses hold under back-pressure.
    a_ifu_r_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_r.valid && !ifu_rready |=> ifu_r.valid && $stable(ifu_r.data))
        else $error("ifu r dropped or changed before rready");
    a_lsu_r_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_r.valid && !lsu_rready |=> lsu_r.valid && $stable(lsu_r.data)
        && $stable(lsu_r.resp))
        else $error("lsu r dropped or changed before rready");
    a_lsu_b_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_b.valid && !lsu_bready |=> lsu_b.valid && $stable(lsu_b.resp))
        else $error("lsu b dropped or changed before bready");

    // one master at the sram.
    a_sram_excl: assert property (@(posedge clk) disable iff (rst)
        !(ifu_arready && (lsu_arready || lsu_awready || lsu_wready)))
        else $error("ifu and lsu requests accepted in the same cycle");
    a_sram_src: assert property (@(posedge clk) disable iff (rst)
        sram_ar.valid && sram_arready |-> ifu_ar.valid && ifu_arready
        || lsu_ar.valid && lsu_arready)
        else $error("sram read accepted without a master handshake");

    a_ifu_grant: assert property (@(posedge clk) disable iff (rst)
        ifu_r.valid |-> state == 2'd1)
        else $error("ifu r valid without ifu grant");
    a_lsu_grant: assert property (@(posedge clk) disable iff (rst)
        lsu_r.valid || lsu_b.valid |-> state == 2'd2)
        else $error("lsu response valid without lsu grant");

endmodule

// File: hw/soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axi_ar_t    ifu_ar,
    output logic       ifu_arready,
    output axi_r_t     ifu_r,
    input  logic       ifu_rready,

    input  axi_ar_t    lsu_ar,
    output logic       lsu_arready,
    input  axi_aw_t    lsu_aw,
    output logic       lsu_awready,
    input  axi_w_t     lsu_w,
    output logic       lsu_wready,
    output axi_r_t     lsu_r,
    input  logic       lsu_rready,
    output axi_b_t     lsu_b,
    input  logic       lsu_bready,

    output logic [7:0] tx_byte,
    output logic       tx_strobe
);

    axi_ar_t sram_ar, uart_ar, clint_ar;
    axi_aw_t sram_aw, uart_aw;
    axi_w_t  sram_w, uart_w;
    axi_r_t  sram_r, uart_r, clint_r;
    axi_b_t  sram_b, uart_b;
    logic    sram_arready, sram_awready, sram_wready, sram_rready, sram_bready;
    logic    uart_arready, uart_awready, uart_wready, uart_rready, uart_bready;
    logic    clint_arready, clint_rready;

    axi_xbar u_xbar (.*);

    axi_sram u_sram (
        .clk     (clk),
        .rst     (rst),
        .ar      (sram_ar),
        .arready (sram_arready),
        .aw      (sram_aw),
        .awready (sram_awready),
        .w       (sram_w),
        .wready  (sram_wready),
        .r       (sram_r),
        .rready  (sram_rready),
        .b       (sram_b),
        .bready  (sram_bready)
    );

    axi_uart u_uart (
        .clk       (clk),
        .rst       (rst),
        .ar        (uart_ar),
        .arready   (uart_arready),
        .aw        (uart_aw),
        .awready   (uart_awready),
        .w         (uart_w),
        .wready    (uart_wready),
        .r         (uart_r),
        .rready    (uart_rready),
        .b         (uart_b),
        .bready    (uart_bready),
        .tx_byte   (tx_byte),
        .tx_strobe (tx_strobe)
    );

    axi_clint u_clint (
        .clk     (clk),
        .rst     (rst),
        .ar      (clint_ar),
        .arready (clint_arready),
        .r       (clint_r),
        .rready  (clint_rready)
    );

endmodule

// File: hw/axi_clint.sv
`timescale 1ns/1ps

module axi_clint
    import soc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  axi_ar_t ar,
    output logic    arready,
    output axi_r_t  r,
    input  logic    rready
);

    logic [63:0] mtime;
    logic [31:0] hi_snap;       // high half seen at the last low read.
    logic [31:0] rdata_q;
    logic        rvalid_q;

    assign arready = !rvalid_q;
    assign r       = '{data: rdata_q, resp: resp_okay, valid: rvalid_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime    <= 64'h0;
            hi_snap  <= 32'h0;
            rvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar.valid && arready) begin
                rvalid_q <= 1'b1;
                if (ar.addr == clint_lo_addr)
                    hi_snap <= mtime[63:32];
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar.valid && arready)
            rdata_q <= (ar.addr == clint_hi_addr) ? hi_snap : mtime[31:0];
    end

endmodule

// File: hw/axi_uart.sv
`timescale 1ns/1ps

module axi_uart
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axi_ar_t    ar,
    output logic       arready,
    input  axi_aw_t    aw,
    output logic       awready,
    input  axi_w_t     w,
    output logic       wready,
    output axi_r_t     r,
    input  logic       rready,
    output axi_b_t     b,
    input  logic       bready,

    output logic [7:0] tx_byte,
    output logic       tx_strobe
);

    logic [7:0] thr;            // transmit holding register.
    logic       rvalid_q;
    logic       bvalid_q;
    logic       wr_go;

    assign arready = !rvalid_q;
    assign wr_go   = aw.valid && w.valid && !bvalid_q;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign r       = '{data: {24'h0, thr}, resp: resp_okay, valid: rvalid_q};
    assign b       = '{resp: resp_okay, valid: bvalid_q};
    assign tx_byte = thr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            thr       <= 8'h0;
            rvalid_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            tx_strobe <= 1'b0;
        end else begin
            tx_strobe <= wr_go;     // one cycle per accepted write.
            if (wr_go && w.strb[0])
                thr <= w.data[7:0];
            if (ar.valid && arready)
                rvalid_q <= 1'b1;
            else if (rready)
                rvalid_q <= 1'b0;
            if (wr_go)
                bvalid_q <= 1'b1;
            else if (bready)
                bvalid_q <= 1'b0;
        end
    end

endmodule

// File: hw/axi_sram.sv
`timescale 1ns/1ps

module axi_sram
    import soc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  axi_ar_t ar,
    output logic    arready,
    input  axi_aw_t aw,
    output logic    awready,
    input  axi_w_t  w,
    output logic    wready,
    output axi_r_t  r,
    input  logic    rready,
    output axi_b_t  b,
    input  logic    bready
);

    logic [31:0]               mem [sram_words];
    logic [31:0]               rdata_q;
    logic                      rvalid_q;
    logic                      bvalid_q;
    logic                      rd_go;
    logic                      wr_go;
    logic [sram_addr_bits-1:0] ridx;
    logic [sram_addr_bits-1:0] widx;

    // index wraps at the array depth.
    assign ridx = ar.addr[sram_addr_bits+1:2];
    assign widx = aw.addr[sram_addr_bits+1:2];

    assign arready = !rvalid_q;
    assign rd_go   = ar.valid && arready;

    // address and data are taken together.
    assign wr_go   = aw.valid && w.valid && !bvalid_q;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign r = '{data: rdata_q, resp: resp_okay, valid: rvalid_q};
    assign b = '{resp: resp_okay, valid: bvalid_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rd_go)
                rvalid_q <= 1'b1;
            else if (rready)
                rvalid_q <= 1'b0;      // held until taken.
            if (wr_go)
                bvalid_q <= 1'b1;
            else if (bready)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go)
            rdata_q <= mem[ridx];
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i])
                    mem[widx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

endmodule

// File: hw/axi_xbar.sv
`timescale 1ns/1ps

module axi_xbar
    import soc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  axi_ar_t ifu_ar,
    output logic    ifu_arready,
    output axi_r_t  ifu_r,
    input  logic    ifu_rready,

    input  axi_ar_t lsu_ar,
    output logic    lsu_arready,
    input  axi_aw_t lsu_aw,
    output logic    lsu_awready,
    input  axi_w_t  lsu_w,
    output logic    lsu_wready,
    output axi_r_t  lsu_r,
    input  logic    lsu_rready,
    output axi_b_t  lsu_b,
    input  logic    lsu_bready,

    output axi_ar_t sram_ar,
    input  logic    sram_arready,
    output axi_aw_t sram_aw,
    input  logic    sram_awready,
    output axi_w_t  sram_w,
    input  logic    sram_wready,
    input  axi_r_t  sram_r,
    output logic    sram_rready,
    input  axi_b_t  sram_b,
    output logic    sram_bready,

    output axi_ar_t uart_ar,
    input  logic    uart_arready,
    output axi_aw_t uart_aw,
    input  logic    uart_awready,
    output axi_w_t  uart_w,
    input  logic    uart_wready,
    input  axi_r_t  uart_r,
    output logic    uart_rready,
    input  axi_b_t  uart_b,
    output logic    uart_bready,

    output axi_ar_t clint_ar,
    input  logic    clint_arready,
    input  axi_r_t  clint_r,
    output logic    clint_rready
);

    typedef enum logic [1:0] {
        idle,
        grant_ifu,
        grant_lsu
    } xbar_state_t;

    xbar_state_t state;
    slave_sel_t  sel;
    logic        lsu_wr;            // granted lsu transaction is a write.
    logic        err_rvalid;
    logic        err_bvalid;
    logic        rd_lsu;
    logic        wr_lsu;
    logic        err_rd_go;
    logic        err_wr_go;
    logic        lsu_done;

    // clint is read only, so a write there is unmapped.
    function automatic slave_sel_t decode(input logic [31:0] addr, input logic wr);
        slave_sel_t s;
        s = sel_none;
        if (addr[31:sram_addr_bits+2] == sram_base[31:sram_addr_bits+2])
            s = sel_sram;
        else if (addr == uart_addr)
            s = sel_uart;
        else if (!wr && (addr == clint_lo_addr || addr == clint_hi_addr))
            s = sel_clint;
        return s;
    endfunction

    assign rd_lsu    = (state == grant_lsu) && !lsu_wr;
    assign wr_lsu    = (state == grant_lsu) && lsu_wr;
    assign err_rd_go = rd_lsu && (sel == sel_none) && lsu_ar.valid && !err_rvalid;
    assign err_wr_go = wr_lsu && (sel == sel_none) && lsu_aw.valid && lsu_w.valid
                       && !err_bvalid;
    assign lsu_done  = lsu_wr ? (lsu_b.valid && lsu_bready) : (lsu_r.valid && lsu_rready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            sel        <= sel_none;
            lsu_wr     <= 1'b0;
            err_rvalid <= 1'b0;
            err_bvalid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (lsu_aw.valid) begin       // write beats a pending read.
                        state  <= grant_lsu;
                        lsu_wr <= 1'b1;
                        sel    <= decode(lsu_aw.addr, 1'b1);
                    end else if (lsu_ar.valid) begin
                        state  <= grant_lsu;
                        lsu_wr <= 1'b0;
                        sel    <= decode(lsu_ar.addr, 1'b0);
                    end else if (ifu_ar.valid) begin
                        state <= grant_ifu;
                        sel   <= sel_sram;          // fetch only targets memory.
                    end
                end
                grant_ifu: if (ifu_r.valid && ifu_rready) state <= idle;
                grant_lsu: if (lsu_done) state <= idle;
                default: state <= idle;
            endcase

            if (err_rd_go)
                err_rvalid <= 1'b1;
            else if (lsu_rready)
                err_rvalid <= 1'b0;
            if (err_wr_go)
                err_bvalid <= 1'b1;
            else if (lsu_bready)
                err_bvalid <= 1'b0;
        end
    end

    always_comb begin
        sram_ar        = lsu_ar;
        sram_ar.valid  = 1'b0;
        uart_ar        = lsu_ar;
        uart_ar.valid  = 1'b0;
        clint_ar       = lsu_ar;
        clint_ar.valid = 1'b0;
        sram_aw        = lsu_aw;
        sram_aw.valid  = 1'b0;
        uart_aw        = lsu_aw;
        uart_aw.valid  = 1'b0;
        sram_w         = lsu_w;
        sram_w.valid   = 1'b0;
        uart_w         = lsu_w;
        uart_w.valid   = 1'b0;
        sram_rready    = 1'b0;
        uart_rready    = 1'b0;
        clint_rready   = 1'b0;
        sram_bready    = 1'b0;
        uart_bready    = 1'b0;
        ifu_arready    = 1'b0;
        ifu_r          = '{data: 32'h0, resp: resp_okay, valid: 1'b0};
        lsu_arready    = 1'b0;
        lsu_awready    = 1'b0;
        lsu_wready     = 1'b0;
        lsu_r          = '{data: 32'h0, resp: resp_decerr, valid: err_rvalid};
        lsu_b          = '{resp: resp_decerr, valid: err_bvalid};

        if (state == grant_ifu) begin
            sram_ar     = ifu_ar;
            ifu_arready = sram_arready;
            ifu_r       = sram_r;
            sram_rready = ifu_rready;
        end else if (rd_lsu) begin
            case (sel)
                sel_sram: begin
                    sram_ar     = lsu_ar;
                    lsu_arready = sram_arready;
                    lsu_r       = sram_r;
                    sram_rready = lsu_rready;
                end
                sel_uart: begin
                    uart_ar     = lsu_ar;
                    lsu_arready = uart_arready;
                    lsu_r       = uart_r;
                    uart_rready = lsu_rready;
                end
                sel_clint: begin
                    clint_ar     = lsu_ar;
                    lsu_arready  = clint_arready;
                    lsu_r        = clint_r;
                    clint_rready = lsu_rready;
                end
                default: lsu_arready = err_rd_go;
            endcase
        end else if (wr_lsu) begin
            case (sel)
                sel_sram: begin
                    sram_aw     = lsu_aw;
                    sram_w      = lsu_w;
                    lsu_awready = sram_awready;
                    lsu_wready  = sram_wready;
                    lsu_b       = sram_b;
                    sram_bready = lsu_bready;
                end
                sel_uart: begin
                    uart_aw     = lsu_aw;
                    uart_w      = lsu_w;
                    lsu_awready = uart_awready;
                    lsu_wready  = uart_wready;
                    lsu_b       = uart_b;
                    uart_bready = lsu_bready;
                end
                default: begin
                    lsu_awready = err_wr_go;
                    lsu_wready  = err_wr_go;
                end
            endcase
        end
    end

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

    // address map.
    localparam logic [31:0] sram_base      = 32'h8000_0000;
    localparam int          sram_words     = 16384;
    localparam int          sram_addr_bits = 14;     // word index width.
    localparam logic [31:0] uart_addr      = 32'ha000_03f8;
    localparam logic [31:0] clint_lo_addr  = 32'ha000_0048;
    localparam logic [31:0] clint_hi_addr  = 32'ha000_004c;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_decerr = 2'b11;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        valid;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        valid;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axi_b_t;

    // crossbar target, latched at grant.
    typedef enum logic [1:0] {
        sel_sram,
        sel_uart,
        sel_clint,
        sel_none
    } slave_sel_t;

endpackage
